// File: Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - mips_pkg.sv
      - control.sv
      - exc_unit.sv
      - cp0_regs.sv
      - decode_stage.sv
  - target: test
    files:
      - decode_checker.sv
      - tb_decode_stage.sv

// File: control.sv
`timescale 1ns/10ps

module control (
	input  mips_pkg::instr_t   instr,
	input  logic               cpu_mode,
	output mips_pkg::ctrl_t    ctrl,
	output mips_pkg::exc_req_t exc_req,
	output logic [31:0]        imm_ext
);

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [15:0] imm;

	assign opcode = instr.i.opcode;
	assign funct  = instr.r.funct;
	assign imm    = instr.i.imm;

	always_comb begin
		ctrl    = '0;
		exc_req = '0;
		case (opcode)
			mips_pkg::OP_RTYPE: begin
				case (funct)
					mips_pkg::FN_JR: begin
						ctrl.isjump  = 1'b1;
						ctrl.jumpdst = 1'b1;
					end
					mips_pkg::FN_SYS: begin
						exc_req.sys = 1'b1;
					end
					default: begin
						ctrl.regwrite = 1'b1;
						ctrl.regdst   = 1'b1;
					end
				endcase
			end
			mips_pkg::OP_ADDI,
			mips_pkg::OP_SLTI,
			mips_pkg::OP_ANDI,
			mips_pkg::OP_ORI,
			mips_pkg::OP_XORI,
			mips_pkg::OP_LUI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alu_t    = 1'b1;
				ctrl.aluop    = 1'b1;
			end
			mips_pkg::OP_LW: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread  = 1'b1;
				ctrl.alu_t    = 1'b1;
				ctrl.aluop    = 1'b1;
			end
			mips_pkg::OP_LB: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread  = 1'b1;
				ctrl.membyte  = 1'b1;
				ctrl.alu_t    = 1'b1;
				ctrl.aluop    = 1'b1;
			end
			mips_pkg::OP_SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alu_t    = 1'b1;
				ctrl.aluop    = 1'b1;
			end
			mips_pkg::OP_SB: begin
				ctrl.memwrite = 1'b1;
				ctrl.membyte  = 1'b1;
				ctrl.alu_t    = 1'b1;
				ctrl.aluop    = 1'b1;
			end
			mips_pkg::OP_BEQ,
			mips_pkg::OP_BNE: begin
				ctrl.isbranch = 1'b1;
				ctrl.aluop    = 1'b1; // Compare rs against rt
			end
			mips_pkg::OP_J: begin
				ctrl.isjump = 1'b1;
				ctrl.aluop  = 1'b1;
			end
			mips_pkg::OP_JAL: begin
				ctrl.regwrite = 1'b1;
				ctrl.isjump   = 1'b1;
				ctrl.islink   = 1'b1;
				ctrl.aluop    = 1'b1;
			end
			mips_pkg::OP_MFC0: begin
				ctrl.regwrite = 1'b1;
				ctrl.alu_s    = 1'b1; // Coprocessor data takes the rs slot
				ctrl.aluop    = 1'b1;
				exc_req.ri    = ~cpu_mode;
			end
			mips_pkg::OP_MTC0: begin
				ctrl.aluop   = 1'b1;
				ctrl.cowrite = cpu_mode;
				exc_req.ri   = ~cpu_mode;
			end
			mips_pkg::OP_ERET: begin
				exc_req.ri  = ~cpu_mode;
				exc_req.ret = cpu_mode;
			end
			default: begin
				exc_req.ri = 1'b1; // Unknown opcode
			end
		endcase
	end

	// Logical immediates are unsigned, LUI fills the upper half
	always_comb begin
		case (opcode)
			mips_pkg::OP_ANDI,
			mips_pkg::OP_ORI,
			mips_pkg::OP_XORI: imm_ext = {16'h0000, imm};
			mips_pkg::OP_LUI:  imm_ext = {imm, 16'h0000};
			default:           imm_ext = {{16{imm[15]}}, imm};
		endcase
	end

endmodule

// File: cp0_regs.sv
`timescale 1ns/10ps

module cp0_regs (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             instr_valid,
	input  mips_pkg::instr_t instr,
	input  logic [31:0]      instr_pc,
	input  logic [31:0]      rt_data,
	input  logic             cowrite,
	input  mips_pkg::trap_t  trap,
	output logic             cpu_mode,
	output logic [31:0]      epc,
	output logic [31:0]      cp0_rdata
);

	logic        prev_mode;
	logic [4:0]  cause_code;
	logic [4:0]  sel;
	logic        mfc0;
	logic [31:0] rd_mux;

	assign sel  = instr.r.rd;
	assign mfc0 = instr_valid && (instr.i.opcode == mips_pkg::OP_MFC0) && !trap.take;

	// Status holds the mode in bit 0 and the previous mode in bit 1
	always_comb begin
		case (sel)
			mips_pkg::CP0_STATUS: rd_mux = {30'd0, prev_mode, cpu_mode};
			mips_pkg::CP0_CAUSE:  rd_mux = {27'd0, cause_code};
			mips_pkg::CP0_EPC:    rd_mux = epc;
			default:              rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cpu_mode   <= 1'b1; // Start in kernel mode
			prev_mode  <= 1'b1;
			cause_code <= '0;
			epc        <= '0;
		end else if (trap.take) begin
			epc        <= instr_pc;
			cause_code <= trap.code;
			prev_mode  <= cpu_mode;
			cpu_mode   <= 1'b1;
		end else if (trap.is_ret) begin
			cpu_mode <= prev_mode;
		end else if (instr_valid && cowrite) begin
			case (sel)
				mips_pkg::CP0_STATUS: begin
					cpu_mode  <= rt_data[0];
					prev_mode <= rt_data[1];
				end
				mips_pkg::CP0_CAUSE: begin
					cause_code <= rt_data[4:0];
				end
				mips_pkg::CP0_EPC: begin
					epc <= rt_data;
				end
				default: begin
				end
			endcase
		end
	end

	// Read data reflects the registers before this cycle's update
	always_ff @(posedge clk) begin
		cp0_rdata <= mfc0 ? rd_mux : '0;
	end

endmodule

// File: decode_checker.sv
`timescale 1ns/10ps

module decode_checker (
	input logic            clk,
	input logic            rst_n,
	input logic            instr_valid,
	input logic            out_valid,
	input mips_pkg::ctrl_t ctrl_out,
	input mips_pkg::trap_t trap_out
);

	property quiet_in_reset;
		@(posedge clk) !rst_n |-> (!out_valid && !trap_out.take);
	endproperty

	property squash_on_trap;
		@(posedge clk) disable iff (!rst_n)
			trap_out.take |-> (ctrl_out == '0);
	endproperty

	// One register between instr_valid and out_valid
	property valid_one_cycle;
		@(posedge clk) disable iff (!rst_n)
			out_valid == $past(instr_valid);
	endproperty

	reset_outputs_low: assert property (quiet_in_reset)
		else $error("out_valid or trap take is high while reset is asserted");

	trap_ctrl_zero: assert property (squash_on_trap)
		else $error("a taken trap left a nonzero control word");

	valid_latency: assert property (valid_one_cycle)
		else $error("out_valid does not follow instr_valid by one cycle");

endmodule

bind decode_stage decode_checker u_decode_checker (
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.out_valid   (out_valid),
	.ctrl_out    (ctrl_out),
	.trap_out    (trap_out)
);

// File: decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             instr_valid,
	input  mips_pkg::instr_t instr,
	input  logic [31:0]      instr_pc,
	input  logic [31:0]      rt_data,
	output logic             out_valid,
	output mips_pkg::ctrl_t  ctrl_out,
	output logic [31:0]      imm,
	output logic [31:0]      cp0_rdata,
	output mips_pkg::trap_t  trap_out
);

	mips_pkg::ctrl_t    ctrl;
	mips_pkg::exc_req_t exc_req;
	mips_pkg::trap_t    trap;
	logic [31:0]        imm_ext;
	logic [31:0]        epc;
	logic               cpu_mode;
	logic               cp0_cowrite;

	control u_control (
		.instr    (instr),
		.cpu_mode (cpu_mode),
		.ctrl     (ctrl),
		.exc_req  (exc_req),
		.imm_ext  (imm_ext)
	);

	exc_unit u_exc_unit (
		.instr_valid (instr_valid),
		.exc_req     (exc_req),
		.epc         (epc),
		.trap        (trap)
	);

	// A trapping instruction must not touch coprocessor 0
	assign cp0_cowrite = ctrl.cowrite & ~trap.take;

	cp0_regs u_cp0_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.rt_data     (rt_data),
		.cowrite     (cp0_cowrite),
		.trap        (trap),
		.cpu_mode    (cpu_mode),
		.epc         (epc),
		.cp0_rdata   (cp0_rdata)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			ctrl_out  <= '0;
			trap_out  <= '0;
		end else begin
			out_valid <= instr_valid;
			ctrl_out  <= (instr_valid && !trap.take) ? ctrl : '0; // Squash on trap
			trap_out  <= trap;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			imm <= imm_ext;
		end
	end

endmodule

// File: exc_unit.sv
`timescale 1ns/10ps

module exc_unit (
	input  logic               instr_valid,
	input  mips_pkg::exc_req_t exc_req,
	input  logic [31:0]        epc,
	output mips_pkg::trap_t    trap
);

	logic ri;
	logic sys;
	logic ret;

	// Reserved instruction outranks syscall
	assign ri  = instr_valid & exc_req.ri;
	assign sys = instr_valid & exc_req.sys & ~ri;
	assign ret = instr_valid & exc_req.ret & ~ri;

	always_comb begin
		trap        = '0;
		trap.take   = ri | sys;
		trap.is_ret = ret & ~trap.take;
		if (ri) begin
			trap.code = mips_pkg::CAUSE_RI;
		end else if (sys) begin
			trap.code = mips_pkg::CAUSE_SYS;
		end
		if (trap.take) begin
			trap.target = mips_pkg::EXC_VECTOR;
		end else if (trap.is_ret) begin
			trap.target = epc; // Back to the interrupted instruction
		end
	end

endmodule

// File: files.f
mips_pkg.sv
control.sv
exc_unit.sv
cp0_regs.sv
decode_stage.sv
decode_checker.sv
tb_decode_stage.sv

// File: mips_pkg.sv
package mips_pkg;

	// Main opcodes, instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_JAL   = 6'b000011;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_BNE   = 6'b000101;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_SLTI  = 6'b001010;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_MFC0  = 6'b010000; // Coprocessor 0 ops have their own opcodes here
	localparam logic [5:0] OP_MTC0  = 6'b010001;
	localparam logic [5:0] OP_ERET  = 6'b010010;
	localparam logic [5:0] OP_LB    = 6'b100000;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SB    = 6'b101000;
	localparam logic [5:0] OP_SW    = 6'b101011;

	// R-type function codes, instr[5:0]
	localparam logic [5:0] FN_JR  = 6'b001000;
	localparam logic [5:0] FN_SYS = 6'b001100;

	// Coprocessor 0 register numbers, selected by the rd field
	localparam logic [4:0] CP0_STATUS = 5'd12;
	localparam logic [4:0] CP0_CAUSE  = 5'd13;
	localparam logic [4:0] CP0_EPC    = 5'd14;

	localparam logic [4:0] CAUSE_SYS = 5'd8;
	localparam logic [4:0] CAUSE_RI  = 5'd10;

	localparam logic [31:0] EXC_VECTOR = 32'h8000_0180; // All traps enter here

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_r_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} instr_i_t;

	// One instruction word, seen as R-type or as I-type
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

	typedef struct packed {
		logic regwrite;
		logic memtoreg;
		logic memread;
		logic memwrite;
		logic membyte;  // Byte access instead of word
		logic isbranch;
		logic isjump;
		logic jumpdst;  // Jump target taken from rs
		logic islink;
		logic regdst;   // Write rd instead of rt
		logic aluop;
		logic alu_s;
		logic alu_t;    // ALU second operand is the immediate
		logic cowrite;
	} ctrl_t;

	typedef struct packed {
		logic ri;
		logic sys;
		logic ret;
	} exc_req_t;

	typedef struct packed {
		logic        take;
		logic        is_ret;
		logic [4:0]  code;
		logic [31:0] target;
	} trap_t;

endpackage

// File: tb_decode_stage.sv
`timescale 1ns/10ps

module tb_decode_stage;

	typedef struct packed {
		logic             valid;
		mips_pkg::instr_t instr;
		logic [31:0]      pc;
		logic [31:0]      rt_data;
		mips_pkg::ctrl_t  ctrl; // Table control word before any squash
	} row_t;

	typedef struct packed {
		logic            valid;
		mips_pkg::ctrl_t ctrl;
		logic [31:0]     imm;
		logic [31:0]     rdata;
		mips_pkg::trap_t trap;
	} exp_t;

	logic             clk;
	logic             rst_n;
	logic             instr_valid;
	mips_pkg::instr_t instr;
	logic [31:0]      instr_pc;
	logic [31:0]      rt_data;
	logic             out_valid;
	mips_pkg::ctrl_t  ctrl_out;
	logic [31:0]      imm;
	logic [31:0]      cp0_rdata;
	mips_pkg::trap_t  trap_out;

	row_t        rows[$];
	exp_t        pending;
	logic        have_pending;
	logic        m_mode;
	logic        m_pmode;
	logic [31:0] m_epc;
	logic [4:0]  m_cause;
	int          errors;
	int          checks;
	int          cycles;

	decode_stage dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.rt_data     (rt_data),
		.out_valid   (out_valid),
		.ctrl_out    (ctrl_out),
		.imm         (imm),
		.cp0_rdata   (cp0_rdata),
		.trap_out    (trap_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic mips_pkg::instr_t imm_instr(input logic [5:0] op, input logic [15:0] v);
		mips_pkg::instr_t w;
		logic [31:0]      rnd;
		rnd = $urandom;
		w.i.opcode = op;
		w.i.rs = rnd[4:0];
		w.i.rt = rnd[9:5];
		w.i.imm = v;
		return w;
	endfunction

	function automatic mips_pkg::instr_t rtype_instr(input logic [5:0] fn);
		mips_pkg::instr_t w;
		logic [31:0]      rnd;
		rnd = $urandom;
		w.r.opcode = mips_pkg::OP_RTYPE;
		w.r.rs = rnd[4:0];
		w.r.rt = rnd[9:5];
		w.r.rd = rnd[14:10];
		w.r.shamt = 5'd0;
		w.r.funct = fn;
		return w;
	endfunction

	// Coprocessor 0 ops pick the register through rd
	function automatic mips_pkg::instr_t cp0_instr(input logic [5:0] op, input logic [4:0] sel);
		mips_pkg::instr_t w;
		w = rtype_instr(6'd0);
		w.r.opcode = op;
		w.r.rd = sel;
		return w;
	endfunction

	function automatic logic [15:0] random_imm(input logic top);
		logic [31:0] rnd;
		rnd = $urandom;
		return {top, rnd[14:0]};
	endfunction

	function automatic logic known_opcode(input logic [5:0] op);
		case (op)
			mips_pkg::OP_RTYPE, mips_pkg::OP_J, mips_pkg::OP_JAL, mips_pkg::OP_BEQ,
			mips_pkg::OP_BNE, mips_pkg::OP_ADDI, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI,
			mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI, mips_pkg::OP_LW,
			mips_pkg::OP_SW, mips_pkg::OP_LB, mips_pkg::OP_SB, mips_pkg::OP_MFC0,
			mips_pkg::OP_MTC0, mips_pkg::OP_ERET: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] extend_imm(input logic [5:0] op, input logic [15:0] v);
		logic [31:0] x;
		if (op == mips_pkg::OP_ANDI || op == mips_pkg::OP_ORI || op == mips_pkg::OP_XORI) begin
			x = {16'h0000, v};
		end else if (op == mips_pkg::OP_LUI) begin
			x = {v, 16'h0000};
		end else begin
			x = {{16{v[15]}}, v};
		end
		return x;
	endfunction

	function automatic logic [31:0] read_cp0(input logic [4:0] sel);
		logic [31:0] x;
		x = 32'd0;
		if (sel == mips_pkg::CP0_STATUS) x = {30'd0, m_pmode, m_mode};
		if (sel == mips_pkg::CP0_CAUSE) x = {27'd0, m_cause};
		if (sel == mips_pkg::CP0_EPC) x = m_epc;
		return x;
	endfunction

	task automatic add_row(input logic v, input mips_pkg::instr_t w, input logic [31:0] rt,
			input mips_pkg::ctrl_t c);
		row_t r;
		r.valid = v;
		r.instr = w;
		r.pc = 32'h0040_0000 + 32'(rows.size()) * 32'd4;
		r.rt_data = rt;
		r.ctrl = c;
		rows.push_back(r);
	endtask

	// Reference model of one instruction followed by the coprocessor 0 state update
	task automatic predict(input row_t r, output exp_t e);
		logic [5:0] op;
		logic       priv;
		logic       ri;
		logic       sys;
		logic       ret;
		op = r.instr.i.opcode;
		priv = (op == mips_pkg::OP_MFC0) || (op == mips_pkg::OP_MTC0) ||
			(op == mips_pkg::OP_ERET);
		ri = r.valid && (!known_opcode(op) || (priv && !m_mode));
		sys = r.valid && op == mips_pkg::OP_RTYPE && r.instr.r.funct == mips_pkg::FN_SYS;
		ret = r.valid && !ri && op == mips_pkg::OP_ERET;
		e = '0;
		e.valid = r.valid;
		e.imm = extend_imm(op, r.instr.i.imm);
		e.trap.take = ri || sys;
		e.trap.is_ret = ret;
		if (e.trap.take) begin
			e.trap.code = ri ? mips_pkg::CAUSE_RI : mips_pkg::CAUSE_SYS;
			e.trap.target = mips_pkg::EXC_VECTOR;
		end else if (ret) begin
			e.trap.target = m_epc;
		end
		if (r.valid && !e.trap.take) begin
			e.ctrl = r.ctrl;
			if (op == mips_pkg::OP_MFC0) e.rdata = read_cp0(r.instr.r.rd);
		end
		if (e.trap.take) begin
			m_epc = r.pc;
			m_cause = e.trap.code;
			m_pmode = m_mode;
			m_mode = 1'b1;
		end else if (ret) begin
			m_mode = m_pmode;
		end else if (r.valid && op == mips_pkg::OP_MTC0) begin
			if (r.instr.r.rd == mips_pkg::CP0_STATUS) {m_pmode, m_mode} = r.rt_data[1:0];
			if (r.instr.r.rd == mips_pkg::CP0_CAUSE) m_cause = r.rt_data[4:0];
			if (r.instr.r.rd == mips_pkg::CP0_EPC) m_epc = r.rt_data;
		end
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic compare_outputs(input exp_t e);
		check("out_valid", 64'(out_valid), 64'(e.valid));
		check("ctrl_out", 64'(ctrl_out), 64'(e.ctrl));
		check("trap_out", 64'(trap_out), 64'(e.trap));
		check("cp0_rdata", 64'(cp0_rdata), 64'(e.rdata));
		if (e.valid) check("imm", 64'(imm), 64'(e.imm));
	endtask

	task automatic finish_run();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	// Control word columns run regwrite memtoreg memread memwrite membyte isbranch isjump
	// jumpdst islink regdst aluop alu_s alu_t cowrite
	task automatic build_table();
		add_row(1'b1, rtype_instr(6'h20), 32'd0, 14'b10000000010000);
		add_row(1'b1, rtype_instr(mips_pkg::FN_JR), 32'd0, 14'b00000011000000);
		add_row(1'b1, imm_instr(mips_pkg::OP_J, random_imm(1'b0)), 32'd0, 14'b00000010001000);
		add_row(1'b1, imm_instr(mips_pkg::OP_JAL, random_imm(1'b1)), 32'd0, 14'b10000010101000);
		add_row(1'b1, imm_instr(mips_pkg::OP_BEQ, random_imm(1'b1)), 32'd0, 14'b00000100001000);
		add_row(1'b1, imm_instr(mips_pkg::OP_BNE, random_imm(1'b0)), 32'd0, 14'b00000100001000);
		for (int k = 0; k < 4; k++) begin // Both signs of the immediate
			add_row(1'b1, imm_instr(mips_pkg::OP_ADDI, random_imm(k[0])), 32'd0, 14'b10000000001010);
			add_row(1'b1, imm_instr(mips_pkg::OP_SLTI, random_imm(k[0])), 32'd0, 14'b10000000001010);
			add_row(1'b1, imm_instr(mips_pkg::OP_ANDI, random_imm(k[0])), 32'd0, 14'b10000000001010);
			add_row(1'b1, imm_instr(mips_pkg::OP_ORI, random_imm(k[0])), 32'd0, 14'b10000000001010);
			add_row(1'b1, imm_instr(mips_pkg::OP_XORI, random_imm(k[0])), 32'd0, 14'b10000000001010);
			add_row(1'b1, imm_instr(mips_pkg::OP_LUI, random_imm(k[0])), 32'd0, 14'b10000000001010);
			add_row(1'b1, imm_instr(mips_pkg::OP_LW, random_imm(k[0])), 32'd0, 14'b11100000001010);
			add_row(1'b1, imm_instr(mips_pkg::OP_LB, random_imm(k[0])), 32'd0, 14'b11101000001010);
			add_row(1'b1, imm_instr(mips_pkg::OP_SW, random_imm(k[0])), 32'd0, 14'b00010000001010);
			add_row(1'b1, imm_instr(mips_pkg::OP_SB, random_imm(k[0])), 32'd0, 14'b00011000001010);
		end
		add_row(1'b0, imm_instr(mips_pkg::OP_ADDI, random_imm(1'b0)), 32'd0, 14'b0);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MTC0, mips_pkg::CP0_EPC), 32'h1234_5678,
			14'b00000000001001);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_EPC), 32'd0, 14'b10000000001100);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MTC0, mips_pkg::CP0_CAUSE), 32'h15, 14'b00000000001001);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_CAUSE), 32'd0, 14'b10000000001100);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MTC0, mips_pkg::CP0_STATUS), 32'hffff_fffd,
			14'b00000000001001);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_STATUS), 32'd0, 14'b10000000001100);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, 5'd3), 32'd0, 14'b10000000001100);
		for (int k = 0; k < 3; k++) begin // Enter user mode and then try each privileged op
			add_row(1'b1, cp0_instr(mips_pkg::OP_MTC0, mips_pkg::CP0_STATUS), 32'h2,
				14'b00000000001001);
			add_row(1'b1, imm_instr(mips_pkg::OP_ADDI, random_imm(1'b1)), 32'd0, 14'b10000000001010);
			if (k == 0) add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_CAUSE), 32'd0,
				14'b10000000001100);
			if (k == 1) add_row(1'b1, cp0_instr(mips_pkg::OP_MTC0, mips_pkg::CP0_EPC),
				32'hdead_beef, 14'b00000000001001);
			if (k == 2) add_row(1'b1, cp0_instr(mips_pkg::OP_ERET, 5'd0), 32'd0, 14'b0);
			add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_EPC), 32'd0, 14'b10000000001100);
			add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_STATUS), 32'd0,
				14'b10000000001100);
		end
		add_row(1'b1, rtype_instr(mips_pkg::FN_SYS), 32'd0, 14'b0);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_CAUSE), 32'd0, 14'b10000000001100);
		add_row(1'b1, imm_instr(6'b111111, random_imm(1'b0)), 32'd0, 14'b0);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_CAUSE), 32'd0, 14'b10000000001100);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MTC0, mips_pkg::CP0_STATUS), 32'h1, 14'b00000000001001);
		add_row(1'b1, cp0_instr(mips_pkg::OP_ERET, 5'd0), 32'd0, 14'b0);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_STATUS), 32'd0, 14'b10000000001100);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_STATUS), 32'd0, 14'b10000000001100);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MTC0, mips_pkg::CP0_STATUS), 32'h3, 14'b00000000001001);
		add_row(1'b1, cp0_instr(mips_pkg::OP_ERET, 5'd0), 32'd0, 14'b0);
		add_row(1'b1, cp0_instr(mips_pkg::OP_MFC0, mips_pkg::CP0_STATUS), 32'd0, 14'b10000000001100);
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= rows.size() + 50) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycles);
			errors++;
			finish_run();
		end
	end

	initial begin
		void'($urandom(32'ha4ae_23a6));
		errors = 0;
		checks = 0;
		cycles = 0;
		have_pending = 1'b0;
		m_mode = 1'b1; // Kernel mode out of reset
		m_pmode = 1'b1;
		m_epc = 32'd0;
		m_cause = 5'd0;
		rst_n = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		instr_pc = 32'd0;
		rt_data = 32'd0;
		build_table();
		#1 rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		foreach (rows[i]) begin
			@(posedge clk);
			instr_valid <= rows[i].valid;
			instr <= rows[i].instr;
			instr_pc <= rows[i].pc;
			rt_data <= rows[i].rt_data;
			@(negedge clk);
			if (have_pending) compare_outputs(pending); // Results of the previous row
			predict(rows[i], pending);
			have_pending = 1'b1;
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		@(negedge clk);
		compare_outputs(pending);
		finish_run();
	end

endmodule
